// File: verilog/ppu_pkg.sv
/* frame constants, CPU register selects, bus direction codes and the
   packed structs shared by the picture processing unit blocks */

package ppu_pkg;

    // frame geometry, one dot per clock
    localparam logic [8:0] SCREEN_WIDTH = 9'd341;
    localparam logic [8:0] SCREEN_HEIGHT = 9'd262;
    localparam logic [8:0] SCREEN_VISIBLE_WIDTH = 9'd256;
    localparam logic [8:0] SCREEN_VISIBLE_HEIGHT = 9'd240;
    localparam logic [8:0] VBLANK_LINE = 9'd242;

    // start of the palette window on the video bus
    localparam logic [13:0] PALETTE_BASE = 14'h3F00;

    // CPU register selects
    localparam logic [2:0] RS_PPUCTRL = 3'd0;
    localparam logic [2:0] RS_PPUMASK = 3'd1;
    localparam logic [2:0] RS_PPUSTATUS = 3'd2;
    localparam logic [2:0] RS_PPUSCROLL = 3'd5;
    localparam logic [2:0] RS_PPUADDR = 3'd6;
    localparam logic [2:0] RS_PPUDATA = 3'd7;

    // bus direction
    localparam logic RW_READ = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // CPU side register access, valid while cs_n is low
    typedef struct packed {
        logic       cs_n;
        logic       rw;
        logic [2:0] rs;
        logic [7:0] wdata;
    } cpu_bus_t;

    // beam position and visible-region flag
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
        logic       visible;
    } beam_t;

    // video bus request, strobes are active low
    typedef struct packed {
        logic        rd_n;
        logic        we_n;
        logic [13:0] address;
        logic [7:0]  data;
    } vram_req_t;

    // internal register state exposed for debug
    typedef struct packed {
        logic [7:0]  ppuctrl;
        logic [7:0]  ppumask;
        logic [7:0]  scroll_x;
        logic [7:0]  scroll_y;
        logic [13:0] ppuaddr;
        logic        w;
    } ppu_debug_t;

endpackage

// File: verilog/ppu_beam_counter.sv
/* dot and scanline counters with the visible flag and vblank start/end pulses */

`timescale 1ns/1ps

module ppu_beam_counter (
    input  logic            i_clk,
    input  logic            i_reset_n,
    output ppu_pkg::beam_t  o_beam,
    output logic            o_vblank_start,
    output logic            o_vblank_end
);

    import ppu_pkg::*;

    logic [8:0] x;
    logic [8:0] y;
    logic       last_dot;
    logic       last_line;

    assign last_dot = (x == SCREEN_WIDTH - 9'd1);
    assign last_line = (y == SCREEN_HEIGHT - 9'd1);

    // x advances every clock, y on the x wrap
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            x <= '0;
            y <= '0;
        end
        else if (last_dot)
        begin
            x <= '0;
            y <= last_line ? 9'd0 : y + 9'd1;
        end
        else
        begin
            x <= x + 9'd1;
        end
    end

    always_comb
    begin
        o_beam.x = x;
        o_beam.y = y;
        o_beam.visible = (x < SCREEN_VISIBLE_WIDTH) && (y < SCREEN_VISIBLE_HEIGHT);
    end

    // first dot of the vblank line, and the very last dot of the frame
    assign o_vblank_start = (x == 9'd0) && (y == VBLANK_LINE);
    assign o_vblank_end = last_dot && last_line;

endmodule

// File: verilog/ppu_registers.sv
/* CPU register decode: control, mask, scroll and address registers, write toggle,
   vblank flag with interrupt, address stepping, palette/video routing and read mux */

`timescale 1ns/1ps

module ppu_registers (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  ppu_pkg::cpu_bus_t   i_cpu,
    input  logic                i_vblank_start,
    input  logic                i_vblank_end,
    input  logic [7:0]          i_palette_rdata,
    input  logic [7:0]          i_vram_buffer,
    output logic [7:0]          o_data,
    output logic                o_int_n,
    output logic                o_palette_we,
    output logic [4:0]          o_palette_addr,
    output logic [7:0]          o_palette_wdata,
    output logic                o_data_access,
    output logic                o_data_rw,
    output logic [13:0]         o_data_addr,
    output logic [7:0]          o_data_wdata,
    output ppu_pkg::ppu_debug_t o_debug
);

    import ppu_pkg::*;

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic [7:0]  scroll_x;
    logic [7:0]  scroll_y;
    logic [13:0] ppuaddr;
    logic        w;
    logic        vblank;

    logic        cpu_rd;
    logic        cpu_wr;
    logic        status_rd;
    logic        data_access;
    logic        in_palette;
    logic [13:0] addr_step;

    assign cpu_rd = !i_cpu.cs_n && (i_cpu.rw == RW_READ);
    assign cpu_wr = !i_cpu.cs_n && (i_cpu.rw == RW_WRITE);
    assign status_rd = cpu_rd && (i_cpu.rs == RS_PPUSTATUS);
    assign data_access = !i_cpu.cs_n && (i_cpu.rs == RS_PPUDATA);
    assign in_palette = (ppuaddr >= PALETTE_BASE);

    // ppuctrl bit 2 selects a step of one row (32) instead of one byte
    assign addr_step = ppuctrl[2] ? 14'd32 : 14'd1;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ppuctrl <= '0;
            ppumask <= '0;
            scroll_x <= '0;
            scroll_y <= '0;
            ppuaddr <= '0;
            w <= 1'b0;
        end
        else if (status_rd)
        begin
            w <= 1'b0;
        end
        else if (cpu_wr)
        begin
            case (i_cpu.rs)
                RS_PPUCTRL:
                begin
                    ppuctrl <= i_cpu.wdata;
                end
                RS_PPUMASK:
                begin
                    ppumask <= i_cpu.wdata;
                end
                RS_PPUSCROLL:
                begin
                    if (!w)
                        scroll_x <= i_cpu.wdata;
                    else
                        scroll_y <= i_cpu.wdata;
                    w <= !w;
                end
                RS_PPUADDR:
                begin
                    // high byte first, only 6 bits fit the 14-bit address
                    if (!w)
                        ppuaddr[13:8] <= i_cpu.wdata[5:0];
                    else
                        ppuaddr[7:0] <= i_cpu.wdata;
                    w <= !w;
                end
                RS_PPUDATA:
                begin
                    ppuaddr <= ppuaddr + addr_step;
                end
                default:
                begin
                end
            endcase
        end
        else if (data_access)
        begin
            // data reads step the address too
            ppuaddr <= ppuaddr + addr_step;
        end
    end

    // vblank flag, a status read wins over both frame events
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            vblank <= 1'b0;
        else if (status_rd)
            vblank <= 1'b0;
        else if (i_vblank_start)
            vblank <= 1'b1;
        else if (i_vblank_end)
            vblank <= 1'b0;
    end

    assign o_int_n = !(vblank && ppuctrl[7]);

    // palette accesses stay inside the chip
    assign o_palette_we = data_access && cpu_wr && in_palette;
    assign o_palette_addr = ppuaddr[4:0];
    assign o_palette_wdata = i_cpu.wdata;

    // every data access goes to the video port, which drops palette writes
    assign o_data_access = data_access;
    assign o_data_rw = i_cpu.rw;
    assign o_data_addr = ppuaddr;
    assign o_data_wdata = i_cpu.wdata;

    always_comb
    begin
        o_data = 8'h00;
        if (cpu_rd)
        begin
            case (i_cpu.rs)
                RS_PPUSTATUS: o_data = {vblank, 7'b0};
                RS_PPUDATA:   o_data = in_palette ? i_palette_rdata : i_vram_buffer;
                default:      o_data = 8'h00;
            endcase
        end
    end

    always_comb
    begin
        o_debug.ppuctrl = ppuctrl;
        o_debug.ppumask = ppumask;
        o_debug.scroll_x = scroll_x;
        o_debug.scroll_y = scroll_y;
        o_debug.ppuaddr = ppuaddr;
        o_debug.w = w;
    end

endmodule

// File: verilog/ppu_palette_ram.sv
/* 32 x 8 palette memory with the backdrop entries mirrored */

`timescale 1ns/1ps

module ppu_palette_ram (
    input  logic       i_clk,
    input  logic       i_we,
    input  logic [4:0] i_addr,
    input  logic [7:0] i_wdata,
    output logic [7:0] o_rdata
);

    logic [7:0] mem [0:31];
    logic [4:0] index;
    logic       backdrop;

    // entries 0x10, 0x14, 0x18 and 0x1C are the same cells as 0x00..0x0C
    assign backdrop = (i_addr[1:0] == 2'b00);
    assign index = {i_addr[4] && !backdrop, i_addr[3:0]};

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[index] <= i_wdata;
        end
    end

    // asynchronous read, the CPU sees the byte within the access cycle
    assign o_rdata = mem[index];

endmodule

// File: verilog/ppu_vram_port.sv
/* video bus strobe generator with held address/data and the delayed-read buffer */

`timescale 1ns/1ps

module ppu_vram_port (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_access,
    input  logic                i_rw,
    input  logic [13:0]         i_addr,
    input  logic [7:0]          i_wdata,
    input  logic [7:0]          i_vram_data,
    output ppu_pkg::vram_req_t  o_vram,
    output logic [7:0]          o_buffer
);

    import ppu_pkg::*;

    logic        rd_n;
    logic        we_n;
    logic [13:0] address;
    logic [7:0]  data;
    logic [7:0]  buffer;
    logic        start_rd;
    logic        start_wr;

    assign start_rd = i_access && (i_rw == RW_READ);
    // palette writes are handled inside the chip
    assign start_wr = i_access && (i_rw == RW_WRITE) && (i_addr < PALETTE_BASE);

    // strobes last one cycle, the CPU leaves an idle cycle between accesses
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            rd_n <= 1'b1;
            we_n <= 1'b1;
            buffer <= '0;
        end
        else
        begin
            rd_n <= !start_rd;
            we_n <= !start_wr;
            if (!rd_n)
            begin
                // capture as the read strobe ends
                buffer <= i_vram_data;
            end
        end
    end

    // address and write data held through the strobe cycle
    always_ff @(posedge i_clk)
    begin
        if (i_access)
        begin
            address <= i_addr;
            data <= i_wdata;
        end
    end

    always_comb
    begin
        o_vram.rd_n = rd_n;
        o_vram.we_n = we_n;
        o_vram.address = address;
        o_vram.data = data;
    end

    assign o_buffer = buffer;

endmodule

// File: verilog/ppu_top.sv
/* PPU core top: beam counter, register file, palette memory and video bus port */

`timescale 1ns/1ps

module ppu_top (
    input  logic                i_clk,
    input  logic                i_reset_n,

    // CPU side
    input  ppu_pkg::cpu_bus_t   i_cpu,
    output logic [7:0]          o_data,
    output logic                o_int_n,

    // video bus
    output ppu_pkg::vram_req_t  o_vram,
    input  logic [7:0]          i_vram_data,

    // beam position and register state
    output ppu_pkg::beam_t      o_beam,
    output ppu_pkg::ppu_debug_t o_debug
);

    logic        vblank_start;
    logic        vblank_end;

    logic        palette_we;
    logic [4:0]  palette_addr;
    logic [7:0]  palette_wdata;
    logic [7:0]  palette_rdata;

    logic        data_access;
    logic        data_rw;
    logic [13:0] data_addr;
    logic [7:0]  data_wdata;
    logic [7:0]  vram_buffer;

    ppu_beam_counter u_beam (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_beam         (o_beam),
        .o_vblank_start (vblank_start),
        .o_vblank_end   (vblank_end)
    );

    ppu_registers u_regs (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cpu           (i_cpu),
        .i_vblank_start  (vblank_start),
        .i_vblank_end    (vblank_end),
        .i_palette_rdata (palette_rdata),
        .i_vram_buffer   (vram_buffer),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_palette_we    (palette_we),
        .o_palette_addr  (palette_addr),
        .o_palette_wdata (palette_wdata),
        .o_data_access   (data_access),
        .o_data_rw       (data_rw),
        .o_data_addr     (data_addr),
        .o_data_wdata    (data_wdata),
        .o_debug         (o_debug)
    );

    ppu_palette_ram u_palette (
        .i_clk   (i_clk),
        .i_we    (palette_we),
        .i_addr  (palette_addr),
        .i_wdata (palette_wdata),
        .o_rdata (palette_rdata)
    );

    ppu_vram_port u_vram_port (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_access    (data_access),
        .i_rw        (data_rw),
        .i_addr      (data_addr),
        .i_wdata     (data_wdata),
        .i_vram_data (i_vram_data),
        .o_vram      (o_vram),
        .o_buffer    (vram_buffer)
    );

endmodule

// File: tests/ppu_tb_vram.sv
/* behavioural 16 KB video memory that answers the PPU bus strobes */

`timescale 1ns/1ps

module ppu_tb_vram (
    input  logic               i_clk,
    input  ppu_pkg::vram_req_t i_vram,
    output logic [7:0]         o_data
);

    logic [7:0] mem [0:16383];

    // known contents everywhere, each byte mixes both address halves
    initial
    begin
        for (int a = 0; a < 16384; a++)
        begin
            mem[a] = a[7:0] ^ {a[13:8], 2'b10};
        end
    end

    always @(posedge i_clk)
    begin
        if (!i_vram.we_n)
        begin
            mem[i_vram.address] <= i_vram.data;
        end
    end

    // reads answer straight from the address
    assign o_data = mem[i_vram.address];

endmodule

// File: tests/ppu_tb.sv
/* PPU core testbench with clock and reset, stimulus table and expected values,
   compare tasks, beam tracking, vblank interrupt check and timeout */

`timescale 1ns/1ps

module ppu_tb;

    import ppu_pkg::*;

    localparam logic KIND_REG = 1'b0;
    localparam logic KIND_VIDEO = 1'b1;
    // vblank starts after 341 * 242 = 82522 cycles and the rest covers the table
    localparam int TIMEOUT_CYCLES = 100000;
    localparam cpu_bus_t CPU_IDLE = {1'b1, 1'b1, 3'd0, 8'h00};

    typedef struct packed {
        cpu_bus_t   cpu;
        logic [7:0] exp_data;
        ppu_debug_t exp_debug;
        vram_req_t  exp_vram;
        logic       kind;
    } step_t;

    logic       i_clk;
    logic       i_reset_n;
    cpu_bus_t   i_cpu;
    logic [7:0] o_data;
    logic       o_int_n;
    vram_req_t  o_vram;
    logic [7:0] vram_data;
    beam_t      o_beam;
    ppu_debug_t o_debug;

    step_t       steps [0:63];
    int          num_steps = 0;
    int          cycles = 0;
    logic        beam_check_on;
    logic [8:0]  beam_x;
    logic [8:0]  beam_y;

    // reference state that advances while the table is built
    logic [7:0]  shadow [0:16383];
    logic [7:0]  pal [0:31];
    logic [13:0] written_addr [0:15];
    int          num_written = 0;
    logic [7:0]  m_ctrl = '0;
    logic [7:0]  m_mask = '0;
    logic [7:0]  m_sx = '0;
    logic [7:0]  m_sy = '0;
    logic [13:0] m_addr = '0;
    logic        m_w = 1'b0;
    logic [7:0]  m_buf = '0;

    ppu_top i_dut (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_cpu       (i_cpu),
        .o_data      (o_data),
        .o_int_n     (o_int_n),
        .o_vram      (o_vram),
        .i_vram_data (vram_data),
        .o_beam      (o_beam),
        .o_debug     (o_debug)
    );

    ppu_tb_vram vram_model (
        .i_clk  (i_clk),
        .i_vram (o_vram),
        .o_data (vram_data)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Test failures found");
            $fatal(1, "timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // expected beam position over 341 dots and 262 lines
    always @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            beam_x <= '0;
            beam_y <= '0;
        end
        else if (beam_x == 9'd340)
        begin
            beam_x <= '0;
            beam_y <= (beam_y == 9'd261) ? 9'd0 : beam_y + 9'd1;
        end
        else
        begin
            beam_x <= beam_x + 9'd1;
        end
    end

    always @(negedge i_clk)
    begin
        if (beam_check_on)
            check_beam(o_beam, expected_beam(beam_x, beam_y));
    end

    function automatic beam_t expected_beam(input logic [8:0] x, input logic [8:0] y);
        beam_t b;
        b.x = x;
        b.y = y;
        b.visible = (x < 9'd256) && (y < 9'd240);
        return b;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [13:0] addr);
        return addr[7:0] ^ {addr[13:8], 2'b10};
    endfunction

    // the sprite backdrop entries share the background cells
    function automatic logic [4:0] pal_index(input logic [13:0] addr);
        logic [4:0] idx;
        idx = addr[4:0];
        if (idx[4] && (idx[1:0] == 2'b00))
            idx[4] = 1'b0;
        return idx;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic check_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, act, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_debug(input ppu_debug_t act, input ppu_debug_t exp);
        if (act !== exp)
        begin
            $display("FAILED at %0t: o_debug = %h, expected %h", $time, act, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_vram(input vram_req_t act, input vram_req_t exp);
        if (act !== exp)
        begin
            $display("FAILED at %0t: o_vram = %h, expected %h", $time, act, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_beam(input beam_t act, input beam_t exp);
        if (act !== exp)
        begin
            $display("FAILED at %0t: o_beam = %h, expected %h", $time, act, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // one table row with its expected results taken from the reference state
    task automatic add_step(input logic rw, input logic [2:0] rs, input logic [7:0] wdata,
                            input logic kind);
        step_t s;
        logic [13:0] stride;
        stride = m_ctrl[2] ? 14'd32 : 14'd1;
        s.cpu = {1'b0, rw, rs, wdata};
        s.exp_data = 8'h00;
        s.exp_vram = {1'b1, 1'b1, m_addr, wdata};
        s.kind = kind;
        if (rw == RW_READ && rs == RS_PPUSTATUS)
        begin
            // the table ends long before the first vblank
            m_w = 1'b0;
        end
        else if (rw == RW_READ && rs == RS_PPUDATA)
        begin
            s.exp_data = (m_addr >= PALETTE_BASE) ? pal[pal_index(m_addr)] : m_buf;
            m_buf = shadow[m_addr];
            s.exp_vram.rd_n = 1'b0;
            m_addr = m_addr + stride;
        end
        else if (rw == RW_WRITE)
        begin
            case (rs)
                RS_PPUCTRL:
                    m_ctrl = wdata;
                RS_PPUMASK:
                    m_mask = wdata;
                RS_PPUSCROLL:
                begin
                    if (!m_w)
                        m_sx = wdata;
                    else
                        m_sy = wdata;
                    m_w = !m_w;
                end
                RS_PPUADDR:
                begin
                    if (!m_w)
                        m_addr[13:8] = wdata[5:0];
                    else
                        m_addr[7:0] = wdata;
                    m_w = !m_w;
                end
                RS_PPUDATA:
                begin
                    if (m_addr >= PALETTE_BASE)
                    begin
                        pal[pal_index(m_addr)] = wdata;
                    end
                    else
                    begin
                        shadow[m_addr] = wdata;
                        s.exp_vram.we_n = 1'b0;
                        written_addr[num_written] = m_addr;
                        num_written++;
                    end
                    m_addr = m_addr + stride;
                end
                default:
                begin
                end
            endcase
        end
        s.exp_debug = {m_ctrl, m_mask, m_sx, m_sy, m_addr, m_w};
        steps[num_steps] = s;
        num_steps++;
    endtask

    task automatic build_table();
        // control, mask, scroll pairs and the status read clearing the toggle
        add_step(RW_WRITE, RS_PPUMASK, 8'h1E, KIND_REG);
        add_step(RW_WRITE, RS_PPUCTRL, 8'h01, KIND_REG);
        add_step(RW_WRITE, RS_PPUSCROLL, rand_byte(), KIND_REG);
        add_step(RW_WRITE, RS_PPUSCROLL, rand_byte(), KIND_REG);
        add_step(RW_WRITE, RS_PPUSCROLL, 8'h12, KIND_REG);
        add_step(RW_READ, RS_PPUSTATUS, 8'h00, KIND_REG);
        add_step(RW_WRITE, RS_PPUSCROLL, 8'h34, KIND_REG);
        add_step(RW_READ, RS_PPUSTATUS, 8'h00, KIND_REG);
        // video writes with stride 1 then 32
        add_step(RW_WRITE, RS_PPUADDR, 8'h21, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h08, KIND_REG);
        repeat (4) add_step(RW_WRITE, RS_PPUDATA, rand_byte(), KIND_VIDEO);
        add_step(RW_WRITE, RS_PPUCTRL, 8'h04, KIND_REG);
        repeat (3) add_step(RW_WRITE, RS_PPUDATA, rand_byte(), KIND_VIDEO);
        // buffered reads over the bytes just written
        add_step(RW_WRITE, RS_PPUCTRL, 8'h00, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h21, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h08, KIND_REG);
        repeat (5) add_step(RW_READ, RS_PPUDATA, 8'h00, KIND_VIDEO);
        // palette writes where 0x3F10 lands on the 0x3F00 cell
        add_step(RW_WRITE, RS_PPUADDR, 8'h3F, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h10, KIND_REG);
        repeat (2) add_step(RW_WRITE, RS_PPUDATA, rand_byte(), KIND_VIDEO);
        add_step(RW_WRITE, RS_PPUADDR, 8'h3F, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h00, KIND_REG);
        add_step(RW_READ, RS_PPUDATA, 8'h00, KIND_VIDEO);
        add_step(RW_WRITE, RS_PPUADDR, 8'h3F, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h11, KIND_REG);
        add_step(RW_READ, RS_PPUDATA, 8'h00, KIND_VIDEO);
        // buffer now holds the video byte under 0x3F11
        add_step(RW_WRITE, RS_PPUADDR, 8'h21, KIND_REG);
        add_step(RW_WRITE, RS_PPUADDR, 8'h08, KIND_REG);
        add_step(RW_READ, RS_PPUDATA, 8'h00, KIND_VIDEO);
        add_step(RW_WRITE, RS_PPUCTRL, 8'h80, KIND_REG);
    endtask

    // drives one access and returns at the falling edge inside it
    task automatic start_access(input cpu_bus_t c);
        @(posedge i_clk);
        #1;
        i_cpu = c;
        @(negedge i_clk);
    endtask

    // returns at the falling edge of the idle cycle
    task automatic end_access();
        @(posedge i_clk);
        #1;
        i_cpu = CPU_IDLE;
        @(negedge i_clk);
    endtask

    // access cycle followed by the idle cycle that carries the video strobe
    task automatic run_step(input step_t s);
        start_access(s.cpu);
        check_byte("o_data", o_data, s.exp_data);
        // the strobe of the previous step lasted one cycle only
        check_bit("o_vram.rd_n", o_vram.rd_n, 1'b1);
        check_bit("o_vram.we_n", o_vram.we_n, 1'b1);
        end_access();
        check_byte("o_data", o_data, 8'h00);
        check_debug(o_debug, s.exp_debug);
        if (s.kind == KIND_VIDEO)
            check_vram(o_vram, s.exp_vram);
    endtask

    initial
    begin
        logic [31:0] seed_ret;
        i_reset_n = 1'b0;
        i_cpu = CPU_IDLE;
        beam_check_on = 1'b0;
        seed_ret = $urandom(48606);
        for (int a = 0; a < 16384; a++)
            shadow[a] = fill_byte(a[13:0]);
        build_table();

        repeat (2) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        beam_check_on = 1'b1;
        @(negedge i_clk);
        check_debug(o_debug, '0);
        check_bit("o_int_n", o_int_n, 1'b1);
        check_bit("o_vram.rd_n", o_vram.rd_n, 1'b1);
        check_bit("o_vram.we_n", o_vram.we_n, 1'b1);

        for (int i = 0; i < num_steps; i++)
            run_step(steps[i]);
        for (int i = 0; i < num_written; i++)
            check_byte("vram_model.mem", vram_model.mem[written_addr[i]],
                       shadow[written_addr[i]]);

        // the last table row enables the interrupt that vblank raises
        while (o_int_n !== 1'b0)
            @(negedge i_clk);
        check_beam(o_beam, expected_beam(9'd1, 9'd242));

        // the interrupt follows the enable bit while the flag stays set
        start_access({1'b0, RW_WRITE, RS_PPUCTRL, 8'h00});
        end_access();
        check_bit("o_int_n", o_int_n, 1'b1);
        start_access({1'b0, RW_WRITE, RS_PPUCTRL, 8'h80});
        end_access();
        check_bit("o_int_n", o_int_n, 1'b0);

        start_access({1'b0, RW_READ, RS_PPUSTATUS, 8'h00});
        check_byte("o_data", o_data, 8'h80);
        end_access();
        check_bit("o_int_n", o_int_n, 1'b1);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: sources.f
verilog/ppu_pkg.sv
verilog/ppu_beam_counter.sv
verilog/ppu_registers.sv
verilog/ppu_palette_ram.sv
verilog/ppu_vram_port.sv
verilog/ppu_top.sv
tests/ppu_tb_vram.sv
tests/ppu_tb.sv

// File: Bender.yml
package:
  name: ppu_core

sources:
  - verilog/ppu_pkg.sv
  - verilog/ppu_beam_counter.sv
  - verilog/ppu_registers.sv
  - verilog/ppu_palette_ram.sv
  - verilog/ppu_vram_port.sv
  - verilog/ppu_top.sv
  - target: test
    files:
      - tests/ppu_tb_vram.sv
      - tests/ppu_tb.sv
